// ==== rtl/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN    = 64;  // data path width
    localparam int ILEN    = 32;  // instruction and pc width
    localparam int REG_AW  = 5;   // 32 registers
    localparam int IMEM_AW = 6;   // word address, pc[7:2]
    localparam int DMEM_AW = 6;   // low alu result bits
    localparam int PC_STEP = 4;   // one instruction word

    // base opcodes handled by this datapath
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_ADDI   = 7'b0010011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    // three clk steps per instruction
    typedef enum logic [1:0] {
        PH_FETCH  = 2'd0,
        PH_DECODE = 2'd1,
        PH_EXEC   = 2'd2
    } phase_e;

    // format class as sent by the control unit
    typedef enum logic [1:0] {
        CMD_R = 2'd0,
        CMD_I = 2'd1,
        CMD_S = 2'd2,
        CMD_B = 2'd3
    } alu_cmd_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_OR  = 2'd3
    } alu_op_e;

    // bit 0 equal, bit 1 negative, bit 2 overflow
    typedef struct packed {
        logic overflow;
        logic negative;
        logic equal;
    } alu_flags_t;

    // control unit inputs, sampled in exec
    typedef struct packed {
        logic     rf_we;     // register write
        logic     d_mem_we;  // data memory write
        logic     pc_src;    // branch instruction
        logic     rf_src;    // 1 = memory read data
        logic     alu_src;   // 1 = immediate operand
        alu_cmd_e alu_cmd;
    } ctrl_t;

    typedef struct packed {
        logic [REG_AW-1:0] ra;
        logic [REG_AW-1:0] rb;
        logic [REG_AW-1:0] rw;
        logic [2:0]        funct3;
        logic [6:0]        funct7;
        logic [XLEN-1:0]   imm;  // already sign extended
    } decoded_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pc_src,        // branch in exec
    input  logic               branch_equal,  // alu equal flag
    input  logic [XLEN-1:0]    offset,        // branch immediate
    input  logic [ILEN-1:0]    i_mem_data,
    output logic [ILEN-1:0]    instr,
    output phase_e             phase,
    output logic [IMEM_AW-1:0] i_mem_addr
);

    phase_e          phase_nxt;
    logic [ILEN-1:0] pc;
    logic [ILEN-1:0] pc_nxt;
    logic            take_branch;

    // fetch -> decode -> exec -> fetch
    always_comb begin
        case (phase)
            PH_FETCH:  phase_nxt = PH_DECODE;
            PH_DECODE: phase_nxt = PH_EXEC;
            default:   phase_nxt = PH_FETCH;  // exec and the unused code
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_FETCH;
        end else begin
            phase <= phase_nxt;
        end
    end

    assign take_branch = pc_src & branch_equal;
    // offset only matters in its low ILEN bits, pc wraps at 32 bits
    assign pc_nxt = take_branch ? pc + offset[ILEN-1:0] : pc + ILEN'(PC_STEP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (phase == PH_EXEC) begin
            pc <= pc_nxt;  // one update per instruction
        end
    end

    // ir captures memory word at end of fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr <= '0;
        end else if (phase == PH_FETCH) begin
            instr <= i_mem_data;
        end
    end

    assign i_mem_addr = pc[IMEM_AW+1:2];  // word index

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder import rv_pkg::*; (
    input  logic [ILEN-1:0] instr,
    output opcode_e         opcode,
    output decoded_t        fields
);

    logic sign;  // immediate sign, always bit 31

    assign opcode = opcode_e'(instr[6:0]);
    assign sign   = instr[31];

    always_comb begin
        fields = '0;  // unused fields and unknown opcodes stay zero
        case (opcode)
            OP_R: begin
                fields.ra     = instr[19:15];
                fields.rb     = instr[24:20];
                fields.rw     = instr[11:7];
                fields.funct3 = instr[14:12];
                fields.funct7 = instr[31:25];
            end
            OP_LOAD, OP_ADDI: begin
                fields.ra     = instr[19:15];
                fields.rw     = instr[11:7];
                fields.funct3 = instr[14:12];
                fields.imm    = {{52{sign}}, instr[31:20]};  // i format
            end
            OP_STORE: begin
                fields.ra     = instr[19:15];
                fields.rb     = instr[24:20];
                fields.funct3 = instr[14:12];
                fields.imm    = {{52{sign}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                fields.ra     = instr[19:15];
                fields.rb     = instr[24:20];
                fields.funct3 = instr[14:12];
                // b format, halfword offset with implied zero lsb
                fields.imm    = {{51{sign}}, instr[31], instr[7], instr[30:25],
                                 instr[11:8], 1'b0};
            end
            default: begin
                fields = '0;
            end
        endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [REG_AW-1:0] ra,
    input  logic [REG_AW-1:0] rb,
    input  logic [REG_AW-1:0] rw,
    input  logic              we,     // already gated by exec
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rdata_a,
    output logic [XLEN-1:0]   rdata_b
);

    logic [XLEN-1:0] regs [1:31];  // x0 has no storage
    logic [31:1]     wr_sel;       // one-hot write enable

    always_comb begin
        for (int i = 1; i < 32; i++) begin
            wr_sel[i] = we && (rw == REG_AW'(i));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (wr_sel[i]) begin
                    regs[i] <= wdata;
                end
            end
        end
    end

    // index 0 reads back as zero
    assign rdata_a = (ra == '0) ? '0 : regs[ra];
    assign rdata_b = (rb == '0) ? '0 : regs[rb];

endmodule

// ==== rtl/alu_control.sv ====
`timescale 1ns/10ps

module alu_control import rv_pkg::*; (
    input  alu_cmd_e   alu_cmd,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output alu_op_e    op
);

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;  // sub variant

    always_comb begin
        op = ALU_ADD;  // i, s and b formats all add
        if (alu_cmd == CMD_R) begin
            if (funct7 == F7_BASE) begin
                case (funct3)
                    3'd0:    op = ALU_ADD;
                    3'd7:    op = ALU_AND;
                    3'd6:    op = ALU_OR;
                    default: op = ALU_ADD;  // unsupported r ops fall back to add
                endcase
            end else if (funct7 == F7_ALT && funct3 == 3'd0) begin
                op = ALU_SUB;
            end else begin
                op = ALU_ADD;
            end
        end
    end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/10ps

module alu import rv_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] rs2_val,
    input  logic [XLEN-1:0] imm,
    input  logic            alu_src,  // 1 = immediate
    input  alu_op_e         op,
    output logic [XLEN-1:0] result,
    output alu_flags_t      flags
);

    logic [XLEN-1:0] b;
    logic            sa;  // sign of a
    logic            sb;  // sign of operand b
    logic            sr;  // sign of result

    assign b = alu_src ? imm : rs2_val;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            default: result = a | b;  // ALU_OR
        endcase
    end

    assign sa = a[XLEN-1];
    assign sb = b[XLEN-1];
    assign sr = result[XLEN-1];

    assign flags.equal    = (a == b);  // branch compare
    assign flags.negative = sr;

    // signed overflow, meaningful for add and sub only
    always_comb begin
        case (op)
            ALU_ADD: flags.overflow = (sa == sb) && (sr != sa);
            ALU_SUB: flags.overflow = (sa != sb) && (sr != sa);
            default: flags.overflow = 1'b0;
        endcase
    end

endmodule

// ==== rtl/rv_datapath.sv ====
`timescale 1ns/10ps

module rv_datapath import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  ctrl_t              ctrl,         // from the external control unit
    input  logic [ILEN-1:0]    i_mem_data,
    input  logic [XLEN-1:0]    d_mem_rdata,
    output opcode_e            opcode,
    output logic               exec_strobe,
    output logic [IMEM_AW-1:0] i_mem_addr,
    output logic [DMEM_AW-1:0] d_mem_addr,
    output logic [XLEN-1:0]    d_mem_wdata,
    output logic               d_mem_we,
    output alu_flags_t         alu_flags
);

    logic [ILEN-1:0] instr;
    phase_e          phase;
    decoded_t        fields;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic            rf_we;
    alu_op_e         alu_op;

    assign exec_strobe = (phase == PH_EXEC);

    // writes only land in the exec step
    assign rf_we    = ctrl.rf_we & exec_strobe;
    assign d_mem_we = ctrl.d_mem_we & exec_strobe;

    assign wb_data = ctrl.rf_src ? d_mem_rdata : alu_result;  // load vs alu

    assign d_mem_addr  = alu_result[DMEM_AW-1:0];
    assign d_mem_wdata = rdata_b;  // store data from rs2

    fetch_unit fetch_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_src       (ctrl.pc_src),
        .branch_equal (alu_flags.equal),
        .offset       (fields.imm),
        .i_mem_data   (i_mem_data),
        .instr        (instr),
        .phase        (phase),
        .i_mem_addr   (i_mem_addr)
    );

    instr_decoder instr_decoder_inst (
        .instr  (instr),
        .opcode (opcode),
        .fields (fields)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (fields.ra),
        .rb      (fields.rb),
        .rw      (fields.rw),
        .we      (rf_we),
        .wdata   (wb_data),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    alu_control alu_control_inst (
        .alu_cmd (ctrl.alu_cmd),
        .funct3  (fields.funct3),
        .funct7  (fields.funct7),
        .op      (alu_op)
    );

    alu alu_inst (
        .a       (rdata_a),
        .rs2_val (rdata_b),
        .imm     (fields.imm),
        .alu_src (ctrl.alu_src),
        .op      (alu_op),
        .result  (alu_result),
        .flags   (alu_flags)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // reset held for 16 rising edges, released on an edge
    initial begin
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/rv_datapath_sva.sv ====
`timescale 1ns/10ps

module rv_datapath_sva import rv_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               exec_strobe,
    input opcode_e            opcode,
    input logic [IMEM_AW-1:0] i_mem_addr
);

    int fail_count = 0;  // read by the testbench at the end

    // exec once per three cycles, two quiet cycles between
    strobe_period: assert property (@(posedge clk) disable iff (!rst_n)
        exec_strobe |=> !exec_strobe ##1 !exec_strobe ##1 exec_strobe)
        else begin
            $error("exec_strobe is not followed by two low cycles and a high one");
            fail_count++;
        end

    // ir holds from decode through exec
    opcode_held: assert property (@(posedge clk) disable iff (!rst_n)
        exec_strobe |-> $stable(opcode))
        else begin
            $error("opcode changed between the decode and exec steps");
            fail_count++;
        end

    // pc moves only at the edge that ends exec
    pc_after_exec: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(i_mem_addr) |-> $past(exec_strobe))
        else begin
            $error("i_mem_addr changed without a preceding exec step");
            fail_count++;
        end

endmodule

// ==== bench/rv_datapath_tb.sv ====
`timescale 1ns/10ps

module rv_datapath_tb import rv_pkg::*; ();

    typedef enum int {T_RESET, T_ARITH, T_MEM, T_BRANCH, T_FLAGS, T_ZERO} test_e;

    // what one instruction should do, from the isa rules
    typedef struct packed {
        logic [XLEN-1:0]   result;  // alu result, also the memory address
        alu_flags_t        flags;
        logic              reg_we;
        logic [REG_AW-1:0] rw;
        logic [XLEN-1:0]   wb;
        logic              mem_we;
        logic [XLEN-1:0]   store_data;
        logic [ILEN-1:0]   next_pc;
    } expected_t;

    logic               clk;
    logic               rst_n;
    ctrl_t              ctrl = '0;
    logic [ILEN-1:0]    i_mem_data;
    logic [XLEN-1:0]    d_mem_rdata;
    opcode_e            opcode;
    logic               exec_strobe;
    logic [IMEM_AW-1:0] i_mem_addr;
    logic [DMEM_AW-1:0] d_mem_addr;
    logic [XLEN-1:0]    d_mem_wdata;
    logic               d_mem_we;
    alu_flags_t         alu_flags;

    logic [ILEN-1:0]    imem [0:(1<<IMEM_AW)-1];
    test_e              tags [0:(1<<IMEM_AW)-1];  // which test owns each word
    logic [XLEN-1:0]    dmem [0:(1<<DMEM_AW)-1];
    logic [XLEN-1:0]    ref_mem [0:(1<<DMEM_AW)-1];
    logic [XLEN-1:0]    ref_regs [0:31];
    logic [ILEN-1:0]    ref_pc = '0;
    logic [IMEM_AW-1:0] pc_expect;
    int                 checks [6];
    int                 errs [6];
    int                 prog_len = 0;
    int                 limit;
    int                 cycles = 0;
    int                 since_rst = 0;
    logic               first_exec = 1'b1;
    logic               pc_pending = 1'b0;
    logic               run_done = 1'b0;

    tb_clock tb_clock_inst (.clk(clk), .rst_n(rst_n));
    rv_datapath rv_datapath_inst (.*);
    bind rv_datapath rv_datapath_sva rv_datapath_sva_inst (.*);

    assign i_mem_data  = imem[i_mem_addr];  // same-cycle memories
    assign d_mem_rdata = dmem[d_mem_addr];

    function automatic logic [ILEN-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [ILEN-1:0] i_type(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [ILEN-1:0] s_type(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [ILEN-1:0] b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] fill_word(input int i);
        return {32'hd00d_0000 | 32'(i), 32'(i) * 32'h9e37_79b9};
    endfunction

    // plays the control unit
    function automatic ctrl_t control_for(input opcode_e op);
        ctrl_t c;
        c = '0;
        c.alu_cmd = CMD_R;
        case (op)
            OP_R: c.rf_we = 1'b1;
            OP_ADDI: begin
                c.rf_we   = 1'b1;
                c.alu_src = 1'b1;
                c.alu_cmd = CMD_I;
            end
            OP_LOAD: begin
                c.rf_we   = 1'b1;
                c.rf_src  = 1'b1;  // write back memory data
                c.alu_src = 1'b1;
                c.alu_cmd = CMD_I;
            end
            OP_STORE: begin
                c.d_mem_we = 1'b1;
                c.alu_src  = 1'b1;
                c.alu_cmd  = CMD_S;
            end
            OP_BRANCH: begin
                c.pc_src  = 1'b1;
                c.alu_cmd = CMD_B;
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    // reference model, reads the reference registers and memory
    function automatic expected_t predict(input logic [ILEN-1:0] ins, input logic [ILEN-1:0] pc);
        expected_t       e;
        logic [6:0]      op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN:0]   wide;  // sign-extended sum, one guard bit
        logic            do_sub;
        logic            logic_op;
        e        = '0;
        op       = ins[6:0];
        a        = ref_regs[ins[19:15]];
        b        = ref_regs[ins[24:20]];
        e.rw     = ins[11:7];
        do_sub   = 1'b0;
        logic_op = 1'b0;
        e.store_data = b;
        case (op)
            OP_LOAD, OP_ADDI: imm = XLEN'($signed(ins[31:20]));
            OP_STORE:         imm = XLEN'($signed({ins[31:25], ins[11:7]}));
            OP_BRANCH:        imm = XLEN'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
            default:          imm = '0;
        endcase
        if (op != OP_R && op != OP_BRANCH) begin
            b = imm;  // immediate forms
        end
        if (op == OP_R) begin
            case ({ins[31:25], ins[14:12]})
                {7'h20, 3'd0}: begin
                    e.result = a - b;
                    do_sub   = 1'b1;
                end
                {7'h00, 3'd7}: begin
                    e.result = a & b;
                    logic_op = 1'b1;
                end
                {7'h00, 3'd6}: begin
                    e.result = a | b;
                    logic_op = 1'b1;
                end
                default: e.result = a + b;
            endcase
        end else begin
            e.result = a + b;  // address and compare forms add
        end
        wide = do_sub ? {a[XLEN-1], a} - {b[XLEN-1], b} : {a[XLEN-1], a} + {b[XLEN-1], b};
        e.flags.equal    = (a == b);
        e.flags.negative = e.result[XLEN-1];
        e.flags.overflow = !logic_op && (wide[XLEN] != wide[XLEN-1]);
        e.reg_we  = (op == OP_R || op == OP_ADDI || op == OP_LOAD);
        e.wb      = (op == OP_LOAD) ? ref_mem[e.result[DMEM_AW-1:0]] : e.result;
        e.mem_we  = (op == OP_STORE);
        e.next_pc = (op == OP_BRANCH && a == b) ? pc + imm[ILEN-1:0] : pc + ILEN'(PC_STEP);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp, input test_e t);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic show_test(input test_e t);
        $display("test %s: %0d checks, %0d errors", t.name(), checks[t], errs[t]);
    endtask

    task automatic put(input logic [ILEN-1:0] ins, input test_e t);
        imem[prog_len] = ins;
        tags[prog_len] = t;
        prog_len++;
    endtask

    task automatic build_program();
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [6:0]        f7;
        logic [2:0]        f3;
        logic [4:0]        a;  // lower half of data memory
        for (int k = 1; k <= 6; k++) begin
            put(i_type(OP_ADDI, REG_AW'(k), '0, 12'($urandom)), T_ARITH);  // seed x1..x6
        end
        // large negative fill word at 60 drives signed overflow
        put(i_type(OP_LOAD, 5'd17, '0, 12'd60), T_FLAGS);
        put(r_type(7'h00, 3'd0, 5'd18, 5'd17, 5'd17), T_FLAGS);
        put(r_type(7'h00, 3'd0, 5'd19, 5'd18, 5'd17), T_FLAGS);  // add overflow
        put(r_type(7'h20, 3'd0, 5'd20, 5'd19, 5'd17), T_FLAGS);  // sub overflow
        for (int k = 0; k < 8; k++) begin
            rd  = REG_AW'($urandom_range(7, 12));
            rs1 = REG_AW'($urandom_range(1, 12));
            rs2 = REG_AW'($urandom_range(1, 12));
            case ($urandom_range(0, 3))
                0:       {f7, f3} = {7'h00, 3'd0};  // add
                1:       {f7, f3} = {7'h20, 3'd0};  // sub
                2:       {f7, f3} = {7'h00, 3'd7};  // and
                default: {f7, f3} = {7'h00, 3'd6};  // or
            endcase
            put(r_type(f7, f3, rd, rs1, rs2), T_ARITH);
        end
        for (int k = 1; k <= 12; k++) begin
            put(s_type(REG_AW'(k), '0, 12'($urandom)), T_ARITH);  // expose each register
        end
        // store, load back, store again 32 words up
        a = 5'($urandom);
        put(s_type(REG_AW'($urandom_range(1, 12)), '0, {7'd0, a}), T_MEM);
        put(i_type(OP_LOAD, 5'd13, '0, {7'd0, a}), T_MEM);
        put(s_type(5'd13, '0, {7'd1, a}), T_MEM);
        put(b_type(5'd1, 5'd1, 13'd8), T_BRANCH);                  // always taken
        put(i_type(OP_ADDI, 5'd14, '0, 12'h7ff), T_BRANCH);        // skipped
        put(b_type(5'd1, 5'd2, 13'd8), T_BRANCH);                  // random operands
        put(i_type(OP_ADDI, 5'd15, '0, 12'($urandom)), T_BRANCH);
        rs1 = REG_AW'($urandom_range(1, 12));
        put(b_type(rs1, rs1, 13'd12), T_BRANCH);                   // skips two
        put(i_type(OP_ADDI, 5'd14, 5'd14, 12'h123), T_BRANCH);
        put(i_type(OP_ADDI, 5'd15, 5'd15, 12'h456), T_BRANCH);
        put(s_type(5'd14, '0, 12'd48), T_BRANCH);
        put(s_type(5'd15, '0, 12'd49), T_BRANCH);
        put(i_type(OP_ADDI, '0, '0, 12'($urandom) | 12'd1), T_ZERO);  // x0 targets
        put(r_type(7'h00, 3'd0, '0, 5'd1, 5'd2), T_ZERO);
        put(s_type('0, '0, 12'd50), T_ZERO);
        put(r_type(7'h00, 3'd6, 5'd16, '0, '0), T_ZERO);
        put(s_type(5'd16, '0, 12'd51), T_ZERO);
    endtask

    task automatic report_and_finish();
        int    total_checks;
        int    total_errs;
        int    sva_fails;
        test_e t;
        total_checks = 0;
        total_errs   = 0;
        sva_fails    = rv_datapath_inst.rv_datapath_sva_inst.fail_count;
        for (int i = 0; i < (1<<DMEM_AW); i++) begin
            check_value($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i], T_MEM);
        end
        for (int i = 1; i < 6; i++) begin
            t = test_e'(i);
            show_test(t);
        end
        for (int i = 0; i < 6; i++) begin
            total_checks += checks[i];
            total_errs   += errs[i];
        end
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errs, sva_fails);
        if (total_errs == 0 && sva_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h5331f02c));
        for (int i = 0; i < (1<<IMEM_AW); i++) begin
            imem[i] = i_type(OP_ADDI, '0, '0, 12'(i));  // filler past the program
            tags[i] = T_ZERO;
        end
        for (int i = 0; i < (1<<DMEM_AW); i++) begin
            dmem[i]    = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        build_program();
        limit = prog_len * 3 + 16 + 50;  // three cycles each, reset, margin
    end

    // control unit and data memory
    always @(posedge clk) begin
        ctrl <= control_for(opcode);  // decode opcode sets ctrl for exec
        if (d_mem_we) begin
            dmem[d_mem_addr] <= d_mem_wdata;
        end
    end

    always @(posedge clk) begin
        expected_t          e;
        test_e              t;
        logic [IMEM_AW-1:0] idx;
        cycles++;
        if (cycles > limit) begin
            $display("timeout: program did not finish within %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end else if (!rst_n) begin
            check_value("exec_strobe", XLEN'(exec_strobe), '0, T_RESET);
            check_value("d_mem_we", XLEN'(d_mem_we), '0, T_RESET);
            check_value("i_mem_addr", XLEN'(i_mem_addr), '0, T_RESET);
        end else begin
            since_rst++;
            if (pc_pending) begin
                check_value("i_mem_addr", XLEN'(i_mem_addr), XLEN'(pc_expect), T_BRANCH);
                pc_pending = 1'b0;
            end
            if (run_done) begin
                report_and_finish();
            end else if (exec_strobe) begin
                if (first_exec) begin
                    check_value("cycles to first exec", XLEN'(since_rst), XLEN'(3), T_RESET);
                    show_test(T_RESET);
                    first_exec = 1'b0;
                end
                idx = ref_pc[IMEM_AW+1:2];
                e   = predict(imem[idx], ref_pc);
                t   = tags[idx];
                check_value("opcode", XLEN'(opcode), XLEN'(imem[idx][6:0]), t);
                check_value("alu_flags", XLEN'(alu_flags), XLEN'(e.flags), T_FLAGS);
                check_value("d_mem_we", XLEN'(d_mem_we), XLEN'(e.mem_we), t);
                if (e.mem_we || imem[idx][6:0] == OP_LOAD) begin
                    check_value("d_mem_addr", XLEN'(d_mem_addr),
                                XLEN'(e.result[DMEM_AW-1:0]), t);
                end
                if (e.mem_we) begin
                    check_value("d_mem_wdata", d_mem_wdata, e.store_data, t);
                    ref_mem[e.result[DMEM_AW-1:0]] = e.store_data;
                end
                if (e.reg_we && e.rw != '0) begin
                    ref_regs[e.rw] = e.wb;  // x0 never written
                end
                ref_pc     = e.next_pc;
                pc_expect  = ref_pc[IMEM_AW+1:2];
                pc_pending = 1'b1;
                run_done   = (int'(ref_pc >> 2) >= prog_len);
            end else if (first_exec) begin
                check_value("i_mem_addr", XLEN'(i_mem_addr), '0, T_RESET);  // still at 0
            end
        end
    end

endmodule

// ==== rv_datapath.f ====
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu_control.sv
rtl/alu.sv
rtl/rv_datapath.sv
bench/tb_clock.sv
bench/rv_datapath_sva.sv
bench/rv_datapath_tb.sv
